/* common/mmuPkg.sv */
package mmuPkg;

  localparam int PageBits = 12; // 4 KiB pages.
  localparam int VpnBits = 32 - PageBits;
  localparam int TlbIndexBits = 4; // 16 buffer entries.
  localparam int TagBits = VpnBits - TlbIndexBits;

  // Status seen by the client.
  typedef enum logic [1:0] {
    statReady = 2'd0,
    statBusy = 2'd1,
    statFault = 2'd2
  } memStatusT;

  // Word request, used by the client and again toward the RAM.
  typedef struct packed {
    logic [31:0] addr; // Byte address.
    logic [31:0] wdata;
    logic read;
    logic write;
  } ramReqT;

  // Page-table entry as stored in physical memory.
  typedef struct packed {
    logic valid; // Bit 31.
    logic [10:0] reserved;
    logic [VpnBits-1:0] ppn;
  } pteT;

  // One translation buffer slot.
  typedef struct packed {
    logic valid;
    logic [TagBits-1:0] tag;
    logic [VpnBits-1:0] ppn;
  } tlbEntryT;

endpackage

/* memoryController/transBuffer.sv */
`timescale 1ns/1ns

module transBuffer import mmuPkg::*; #(
  parameter int TlbEntries = 16
) (
  input logic clk,
  input logic rst,
  input logic flush,
  input logic [VpnBits-1:0] lookupVpn,
  output logic hit,
  output logic [VpnBits-1:0] hitPpn,
  input logic refill,
  input logic [VpnBits-1:0] refillVpn,
  input logic [VpnBits-1:0] refillPpn
);

  localparam int IdxBits = $clog2(TlbEntries);

  tlbEntryT entries [TlbEntries];
  tlbEntryT lookupEntry;
  logic [IdxBits-1:0] lookupIdx;
  logic [IdxBits-1:0] refillIdx;

  initial assert (TlbEntries == (1 << TlbIndexBits));

  assign lookupIdx = lookupVpn[IdxBits-1:0];
  assign refillIdx = refillVpn[IdxBits-1:0];
  assign lookupEntry = entries[lookupIdx];

  // Tag is the part of the vpn above the index.
  assign hit = lookupEntry.valid && (lookupEntry.tag == lookupVpn[VpnBits-1:IdxBits]);
  assign hitPpn = lookupEntry.ppn;

  always_ff @(posedge clk)
  begin
    if (rst || flush)
    begin
      for (int i = 0; i < TlbEntries; i++)
      begin
        entries[i].valid <= 1'b0;
      end
    end
    else if (refill)
    begin
      entries[refillIdx].valid <= 1'b1;
      entries[refillIdx].tag <= refillVpn[VpnBits-1:IdxBits];
      entries[refillIdx].ppn <= refillPpn;
    end
  end

  // Flush is only taken while the controller is idle, refill only mid-walk.
  refillNotFlush: assert property (@(posedge clk) disable iff (rst) !(refill && flush));

endmodule

/* memoryController/memoryController.sv */
`timescale 1ns/1ns

module memoryController import mmuPkg::*; #(
  parameter int RamAddrBits = 12,
  parameter int TlbEntries = 16
) (
  input logic clk,
  input logic rst,
  input ramReqT memReq,
  input logic addrVirtual,
  input logic execMode,
  input logic [31:0] kptBase,
  input logic [31:0] uptBase,
  input logic tlbFlush,
  output logic [31:0] memRdata,
  output memStatusT memStatus,
  output ramReqT ramReq,
  input logic ramAck,
  input logic [31:0] ramRdata
);

  localparam logic [31:0] AddrMask = (32'd1 << (RamAddrBits + 2)) - 32'd1;

  typedef enum logic [2:0] {
    sReady,
    sLookup,
    sWalkWait,
    sAccessWait,
    sFault
  } stateT;

  stateT state;
  ramReqT reqQ; // Latched client request.
  logic modeQ;
  logic [31:0] baseQ; // Page-table base for the latched mode.

  logic idle;
  logic accept;
  logic [VpnBits-1:0] vpn;
  logic [PageBits-1:0] offset;
  pteT pte;
  logic kHit;
  logic uHit;
  logic [VpnBits-1:0] kPpn;
  logic [VpnBits-1:0] uPpn;
  logic selHit;
  logic [VpnBits-1:0] selPpn;
  logic refill;
  logic flush;

  assign idle = (state == sReady) || (state == sFault);
  assign accept = idle && (memReq.read || memReq.write);
  assign vpn = reqQ.addr[31:PageBits];
  assign offset = reqQ.addr[PageBits-1:0];
  assign pte = pteT'(ramRdata);

  assign selHit = modeQ ? kHit : uHit;
  assign selPpn = modeQ ? kPpn : uPpn;
  assign refill = (state == sWalkWait) && ramAck && pte.valid;
  assign flush = tlbFlush && idle; // Dropped while busy.

  transBuffer #(
    .TlbEntries(TlbEntries)
  ) kernelTlb (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .lookupVpn(vpn),
    .hit(kHit),
    .hitPpn(kPpn),
    .refill(refill && modeQ),
    .refillVpn(vpn),
    .refillPpn(pte.ppn)
  );

  transBuffer #(
    .TlbEntries(TlbEntries)
  ) userTlb (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .lookupVpn(vpn),
    .hit(uHit),
    .hitPpn(uPpn),
    .refill(refill && !modeQ),
    .refillVpn(vpn),
    .refillPpn(pte.ppn)
  );

  always_comb
  begin
    case (state)
      sReady: memStatus = statReady;
      sFault: memStatus = statFault;
      default: memStatus = statBusy;
    endcase
  end

  always_ff @(posedge clk)
  begin
    ramReq.read <= 1'b0; // Strobes last one cycle.
    ramReq.write <= 1'b0;
    if (rst)
    begin
      state <= sReady;
    end
    else
    begin
      case (state)
        sReady, sFault:
        begin
          if (accept)
          begin
            reqQ <= memReq;
            modeQ <= execMode;
            baseQ <= execMode ? kptBase : uptBase;
            if (addrVirtual)
            begin
              state <= sLookup;
            end
            else
            begin
              ramReq.addr <= memReq.addr & AddrMask;
              ramReq.wdata <= memReq.wdata;
              ramReq.read <= memReq.read;
              ramReq.write <= memReq.write;
              state <= sAccessWait;
            end
          end
        end
        sLookup:
        begin
          if (selHit)
          begin
            ramReq.addr <= {selPpn, offset} & AddrMask;
            ramReq.wdata <= reqQ.wdata;
            ramReq.read <= reqQ.read;
            ramReq.write <= reqQ.write;
            state <= sAccessWait;
          end
          else
          begin
            ramReq.addr <= (baseQ + {10'd0, vpn, 2'b00}) & AddrMask; // Entry at base + 4 * vpn.
            ramReq.read <= 1'b1;
            state <= sWalkWait;
          end
        end
        sWalkWait:
        begin
          if (ramAck)
          begin
            if (pte.valid)
            begin
              ramReq.addr <= {pte.ppn, offset} & AddrMask;
              ramReq.wdata <= reqQ.wdata;
              ramReq.read <= reqQ.read;
              ramReq.write <= reqQ.write;
              state <= sAccessWait;
            end
            else
            begin
              state <= sFault;
            end
          end
        end
        sAccessWait:
        begin
          if (ramAck)
          begin
            if (reqQ.read)
            begin
              memRdata <= ramRdata;
            end
            state <= sReady;
          end
        end
        default: state <= sReady;
      endcase
    end
  end

  noReqWhileBusy: assert property (@(posedge clk) disable iff (rst)
    (memStatus == statBusy) |-> !(memReq.read || memReq.write));

  ackOnlyWaiting: assert property (@(posedge clk) disable iff (rst)
    ramAck |-> (state inside {sWalkWait, sAccessWait}));

  // Client never asks for both at once.
  readXorWrite: assert property (@(posedge clk) disable iff (rst)
    !(memReq.read && memReq.write));

endmodule

/* verilog/physRam.sv */
`timescale 1ns/1ns

module physRam import mmuPkg::*; #(
  parameter int RamAddrBits = 12
) (
  input logic clk,
  input ramReqT ramReq,
  output logic ramAck,
  output logic [31:0] ramRdata
);

  localparam int Words = 1 << RamAddrBits;

  logic [31:0] mem [Words];
  logic [RamAddrBits-1:0] idx;
  logic ackStage1;
  logic [31:0] rdataStage1;

  // Word index, upper address bits wrap.
  assign idx = ramReq.addr[RamAddrBits+1:2];

  always_ff @(posedge clk)
  begin
    if (ramReq.write)
    begin
      mem[idx] <= ramReq.wdata;
    end
    rdataStage1 <= mem[idx];
    ackStage1 <= ramReq.read || ramReq.write;
  end

  // Second stage, ack and data two cycles after the strobe.
  always_ff @(posedge clk)
  begin
    ramAck <= ackStage1;
    ramRdata <= rdataStage1;
  end

endmodule

/* verilog/mmuTop.sv */
`timescale 1ns/1ns

module mmuTop import mmuPkg::*; #(
  parameter int RamAddrBits = 12,
  parameter int TlbEntries = 16
) (
  input logic clk,
  input logic rst,
  input ramReqT memReq,
  input logic addrVirtual,
  input logic execMode,
  input logic [31:0] kptBase,
  input logic [31:0] uptBase,
  input logic tlbFlush,
  output logic [31:0] memRdata,
  output memStatusT memStatus
);

  ramReqT ramReq;
  logic ramAck;
  logic [31:0] ramRdata;

  memoryController #(
    .RamAddrBits(RamAddrBits),
    .TlbEntries(TlbEntries)
  ) ctrl (
    .clk(clk),
    .rst(rst),
    .memReq(memReq),
    .addrVirtual(addrVirtual),
    .execMode(execMode),
    .kptBase(kptBase),
    .uptBase(uptBase),
    .tlbFlush(tlbFlush),
    .memRdata(memRdata),
    .memStatus(memStatus),
    .ramReq(ramReq),
    .ramAck(ramAck),
    .ramRdata(ramRdata)
  );

  physRam #(
    .RamAddrBits(RamAddrBits)
  ) ram (
    .clk(clk),
    .ramReq(ramReq),
    .ramAck(ramAck),
    .ramRdata(ramRdata)
  );

endmodule

/* dv/mmuTbTable.svh */
`ifndef MMU_TB_TABLE_SVH
`define MMU_TB_TABLE_SVH

typedef enum logic [2:0] {
  opPhysWrite,
  opPhysRead,
  opVirtWrite,
  opVirtRead,
  opFlush
} opT;

typedef struct packed {
  opT op;
  logic kernel; // 1 selects kernel translation.
  logic [31:0] addr;
  logic isPte; // Write stores pte instead of random data.
  logic [31:0] pte;
  logic fault; // Access is expected to end in statFault.
} rowT;

localparam int NumRows = 23;

// Columns are op, kernel, addr, isPte, pte, fault.
// User table at 0x1000, kernel table at 0x1800, data pages at ppn 2 and 3.
localparam rowT StimTable [NumRows] = '{
  '{opPhysWrite, 1'b0, 32'h0000_0040, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysWrite, 1'b0, 32'h0001_0080, 1'b0, 32'h0000_0000, 1'b0}, // Wraps to 0x0080.
  '{opPhysRead,  1'b0, 32'h0000_0040, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysRead,  1'b0, 32'h0000_0080, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysWrite, 1'b0, 32'h0000_1014, 1'b1, 32'h8000_0002, 1'b0}, // User vpn 5 to ppn 2.
  '{opVirtWrite, 1'b0, 32'h0000_5120, 1'b0, 32'h0000_0000, 1'b0},
  '{opVirtRead,  1'b0, 32'h0000_5120, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysRead,  1'b0, 32'h0000_2120, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysWrite, 1'b0, 32'h0000_1814, 1'b1, 32'h8000_0003, 1'b0}, // Kernel vpn 5 to ppn 3.
  '{opVirtWrite, 1'b1, 32'h0000_5120, 1'b0, 32'h0000_0000, 1'b0},
  '{opVirtRead,  1'b1, 32'h0000_5120, 1'b0, 32'h0000_0000, 1'b0},
  '{opVirtRead,  1'b0, 32'h0000_5120, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysRead,  1'b0, 32'h0000_3120, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysWrite, 1'b0, 32'h0000_2400, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysWrite, 1'b0, 32'h0000_1024, 1'b1, 32'h0000_0002, 1'b0}, // Vpn 9 entry not valid.
  '{opVirtWrite, 1'b0, 32'h0000_9400, 1'b0, 32'h0000_0000, 1'b1},
  '{opVirtRead,  1'b0, 32'h0000_9400, 1'b0, 32'h0000_0000, 1'b1},
  '{opPhysRead,  1'b0, 32'h0000_2400, 1'b0, 32'h0000_0000, 1'b0},
  '{opPhysWrite, 1'b0, 32'h0000_1014, 1'b1, 32'h8000_0003, 1'b0}, // Remap user vpn 5.
  '{opVirtRead,  1'b0, 32'h0000_5120, 1'b0, 32'h0000_0000, 1'b0},
  '{opFlush,     1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
  '{opVirtRead,  1'b0, 32'h0000_5120, 1'b0, 32'h0000_0000, 1'b0},
  '{opVirtRead,  1'b1, 32'h0000_5120, 1'b0, 32'h0000_0000, 1'b0}
};

`endif

/* dv/mmuTb.sv */
`timescale 1ns/1ns

module mmuTb import mmuPkg::*;;

  `include "mmuTbTable.svh"

  localparam int RamAddrBits = 12;
  localparam int TlbEntries = 1 << TlbIndexBits;
  localparam logic [31:0] UptBase = 32'h0000_1000;
  localparam logic [31:0] KptBase = 32'h0000_1800;
  localparam int CycleLimit = 40 * NumRows + 8;

  logic clk = 1'b0;
  logic rst;
  ramReqT memReq;
  logic addrVirtual;
  logic execMode;
  logic [31:0] kptBase;
  logic [31:0] uptBase;
  logic tlbFlush;
  logic [31:0] memRdata;
  memStatusT memStatus;

  integer seed = 32'hc6964d9e;
  int cycles = 0;

  logic [31:0] shadow [1 << RamAddrBits]; // Expected RAM contents.
  logic mValid [2][TlbEntries]; // Expected buffer state per mode.
  logic [VpnBits-1:0] mVpn [2][TlbEntries];
  logic [VpnBits-1:0] mPpn [2][TlbEntries];

  mmuTop #(
    .RamAddrBits(RamAddrBits),
    .TlbEntries(TlbEntries)
  ) mmuTop_inst (
    .clk(clk),
    .rst(rst),
    .memReq(memReq),
    .addrVirtual(addrVirtual),
    .execMode(execMode),
    .kptBase(kptBase),
    .uptBase(uptBase),
    .tlbFlush(tlbFlush),
    .memRdata(memRdata),
    .memStatus(memStatus)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit)
    begin
      $display("Timeout after %0d cycles, an access never completed", CycleLimit);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error: %s is 0x%08h, expected 0x%08h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [RamAddrBits-1:0] wordIdx(input logic [31:0] addr);
    return addr[RamAddrBits+1:2]; // Upper bits wrap.
  endfunction

  task automatic clearBuffers();
    for (int m = 0; m < 2; m++)
    begin
      for (int i = 0; i < TlbEntries; i++)
      begin
        mValid[m][i] = 1'b0;
      end
    end
  endtask

  // Buffer lookup, then a walk through the shadow page table on a miss.
  task automatic translate(input logic kernel, input logic [31:0] vaddr,
                           output logic fault, output logic [31:0] paddr);
    logic [VpnBits-1:0] vpn;
    logic [TlbIndexBits-1:0] idx;
    logic [31:0] base;
    logic [VpnBits-1:0] ppn;
    pteT pte;
    vpn = vaddr[31:PageBits];
    idx = vpn[TlbIndexBits-1:0];
    fault = 1'b0;
    if (mValid[kernel][idx] && (mVpn[kernel][idx] == vpn))
      ppn = mPpn[kernel][idx];
    else
    begin
      base = kernel ? KptBase : UptBase;
      pte = pteT'(shadow[wordIdx(base + 32'(vpn) * 32'd4)]);
      ppn = pte.ppn;
      if (pte.valid)
      begin
        mValid[kernel][idx] = 1'b1;
        mVpn[kernel][idx] = vpn;
        mPpn[kernel][idx] = ppn;
      end
      else
        fault = 1'b1;
    end
    paddr = {ppn, vaddr[PageBits-1:0]};
  endtask

  task automatic flushBuffers();
    @(negedge clk);
    tlbFlush = 1'b1;
    @(negedge clk);
    tlbFlush = 1'b0;
    clearBuffers();
  endtask

  task automatic access(input rowT r);
    logic isVirt;
    logic isWrite;
    logic fault;
    logic [31:0] paddr;
    logic [31:0] data;
    isVirt = (r.op == opVirtWrite) || (r.op == opVirtRead);
    isWrite = (r.op == opPhysWrite) || (r.op == opVirtWrite);
    if (r.isPte)
      data = r.pte;
    else
      data = $random(seed);
    fault = 1'b0;
    paddr = r.addr;
    if (isVirt)
      translate(r.kernel, r.addr, fault, paddr);
    @(negedge clk);
    memReq.addr = r.addr;
    memReq.wdata = data;
    memReq.read = !isWrite;
    memReq.write = isWrite;
    addrVirtual = isVirt;
    execMode = r.kernel;
    @(negedge clk);
    memReq.read = 1'b0; // One-cycle strobe.
    memReq.write = 1'b0;
    check("memStatus", 32'(memStatus), 32'(statBusy));
    while (memStatus == statBusy)
      @(negedge clk);
    check("memStatus", 32'(memStatus), r.fault ? 32'(statFault) : 32'(statReady));
    if (!fault && isWrite)
      shadow[wordIdx(paddr)] = data;
    if (!fault && !isWrite)
      check("memRdata", memRdata, shadow[wordIdx(paddr)]);
  endtask

  initial
  begin
    rst = 1'b1;
    memReq = '0;
    addrVirtual = 1'b0;
    execMode = 1'b0;
    kptBase = KptBase;
    uptBase = UptBase;
    tlbFlush = 1'b0;
    for (int i = 0; i < (1 << RamAddrBits); i++)
    begin
      shadow[i] = 32'd0;
    end
    clearBuffers();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NumRows; i++)
    begin
      if (StimTable[i].op == opFlush)
        flushBuffers();
      else
        access(StimTable[i]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* files.f */
+incdir+dv
common/mmuPkg.sv
memoryController/transBuffer.sv
memoryController/memoryController.sv
verilog/physRam.sv
verilog/mmuTop.sv
dv/mmuTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f files.f \
  --top-module mmuTb \
  -o mmuSim

./obj_dir/mmuSim
